// ==== design/flash_bank.sv ====
/* flash array model with no phy timing; every word is set to all ones after
   reset and writes are dropped until busy_o falls */
`timescale 1ns/1ps

module flash_bank import flash_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                we_i,
  input  logic [WordIdxW-1:0] addr_i,
  input  logic [WordW-1:0]    wdata_i,
  output logic [WordW-1:0]    rdata_o,
  output logic                busy_o
);

  logic [WordW-1:0]    mem_q [NumWords];
  logic [WordIdxW-1:0] init_idx_q;
  logic                busy_q;

  // init walk, one word per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b1;
      init_idx_q <= '0;
    end else if (busy_q) begin
      init_idx_q <= init_idx_q + 1'b1;
      // last word written this cycle
      if (init_idx_q == WordIdxW'(NumWords - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // array, init fill has priority
  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      mem_q[init_idx_q] <= '1;
    end else if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read is asynchronous so program can check the old word in the same cycle
  assign rdata_o = mem_q[addr_i];
  assign busy_o  = busy_q;

endmodule

// ==== design/flash_ctrl_arb.sv ====
/* hardware owns the bank whenever hw_req_i is high and software is idle;
   a takeover wipes both fifos, so unread software data is lost */
`timescale 1ns/1ps

module flash_ctrl_arb import flash_ctrl_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // requester control
  input  flash_ctrl_t       sw_ctrl_i,
  input  flash_ctrl_t       hw_ctrl_i,
  input  logic [31:0]       sw_addr_i,
  input  logic [31:0]       hw_addr_i,
  input  logic              hw_req_i,
  output logic              sw_ack_o,
  output logic              hw_ack_o,
  output flash_err_e        sw_err_o,
  output flash_err_e        hw_err_o,

  // requester fifo handshakes
  input  logic              sw_rready_i,
  input  logic              hw_rready_i,
  output logic              sw_rvalid_o,
  output logic              hw_rvalid_o,
  input  logic              sw_wvalid_i,
  input  logic              hw_wvalid_i,
  input  logic [WordW-1:0]  sw_wdata_i,
  input  logic [WordW-1:0]  hw_wdata_i,
  output logic              sw_wready_o,
  output logic              hw_wready_o,

  // shared fifo side
  input  logic              rd_fifo_rvalid_i,
  output logic              rd_fifo_rready_o,
  input  logic              prog_fifo_wready_i,
  output logic              prog_fifo_wvalid_o,
  output logic [WordW-1:0]  prog_fifo_wdata_o,
  output logic              fifo_clr_o,

  // bank still filling itself after reset
  input  logic              flash_phy_busy_i,

  output flash_sel_e        sel_o,

  // muxed link to the engine
  flash_op_if.arb           op
);

  typedef enum logic [1:0] {
    StReset,
    StHw,
    StSwIdle,
    StSwActive
  } state_e;

  state_e      state_q, state_d;
  flash_sel_e  func_sel;
  flash_ctrl_t muxed_ctrl;
  logic [31:0] muxed_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StReset;
    end else begin
      state_q <= state_d;
    end
  end

  // ownership
  always_comb begin
    state_d    = state_q;
    func_sel   = NoneSel;
    fifo_clr_o = 1'b0;
    unique case (state_q)
      StReset: begin
        // nothing selected until the bank is erased
        if (!flash_phy_busy_i) begin
          state_d = StHw;
        end
      end
      StHw: begin
        func_sel = HwSel;
        if (!hw_req_i) begin
          state_d = StSwIdle;
        end
      end
      StSwIdle: begin
        // sw keeps the fifos while idle
        func_sel = SwSel;
        if (hw_req_i) begin
          fifo_clr_o = 1'b1;
          state_d    = StHw;
        end else if (sw_ctrl_i.start) begin
          state_d = StSwActive;
        end
      end
      StSwActive: begin
        // locked until the engine acks
        func_sel = SwSel;
        if (op.ack) begin
          state_d = StSwIdle;
        end
      end
      default: state_d = StReset;
    endcase
  end

  // owner muxing, the other side sees zeros
  always_comb begin
    muxed_ctrl         = '0;
    muxed_addr         = '0;
    sw_ack_o           = 1'b0;
    hw_ack_o           = 1'b0;
    sw_err_o           = ErrNone;
    hw_err_o           = ErrNone;
    sw_rvalid_o        = 1'b0;
    hw_rvalid_o        = 1'b0;
    sw_wready_o        = 1'b0;
    hw_wready_o        = 1'b0;
    rd_fifo_rready_o   = 1'b0;
    prog_fifo_wvalid_o = 1'b0;
    prog_fifo_wdata_o  = '0;
    unique case (func_sel)
      HwSel: begin
        muxed_ctrl         = hw_ctrl_i;
        muxed_addr         = hw_addr_i;
        hw_ack_o           = op.ack;
        hw_err_o           = op.err;
        hw_rvalid_o        = rd_fifo_rvalid_i;
        hw_wready_o        = prog_fifo_wready_i;
        rd_fifo_rready_o   = hw_rready_i;
        prog_fifo_wvalid_o = hw_wvalid_i;
        prog_fifo_wdata_o  = hw_wdata_i;
      end
      SwSel: begin
        muxed_ctrl         = sw_ctrl_i;
        muxed_addr         = sw_addr_i;
        // sw start must not launch in the takeover cycle
        if (fifo_clr_o) begin
          muxed_ctrl.start = 1'b0;
        end
        sw_ack_o           = op.ack;
        sw_err_o           = op.err;
        sw_rvalid_o        = rd_fifo_rvalid_i;
        sw_wready_o        = prog_fifo_wready_i;
        rd_fifo_rready_o   = sw_rready_i;
        prog_fifo_wvalid_o = sw_wvalid_i;
        prog_fifo_wdata_o  = sw_wdata_i;
      end
      default: begin
      end
    endcase
  end

  assign op.ctrl = muxed_ctrl;
  assign op.addr = muxed_addr;
  assign sel_o   = func_sel;

endmodule

// ==== design/flash_ctrl_pkg.sv ====
/* shared sizes and codes for the flash controller; byte addresses are taken
   as word aligned and the low two bits are never checked */
package flash_ctrl_pkg;

  // bus and flash word
  localparam int unsigned WordW = 32;

  // bank geometry
  localparam int unsigned NumWords  = 64;
  localparam int unsigned PageWords = 8;
  localparam int unsigned PageBytes = PageWords * 4;
  localparam int unsigned WordIdxW  = $clog2(NumWords);

  // first byte address that is out of range
  localparam int unsigned FlashBytes = NumWords * 4;

  // fifo sizes
  localparam int unsigned RdFifoDepth   = 4;
  localparam int unsigned ProgFifoDepth = 2;

  // operation codes
  typedef enum logic [1:0] {
    FlashOpRead    = 2'd0,
    FlashOpProgram = 2'd1,
    FlashOpErase   = 2'd2
  } flash_op_e;

  // result codes, valid with ack
  typedef enum logic [1:0] {
    ErrNone  = 2'd0,
    ErrRange = 2'd1,  // word address past the bank
    ErrProg  = 2'd2   // target word still holds data
  } flash_err_e;

  // current owner of the engine
  typedef enum logic [1:0] {
    NoneSel = 2'd0,
    HwSel   = 2'd1,
    SwSel   = 2'd2
  } flash_sel_e;

  // control word from each requester
  typedef struct packed {
    logic      start;  // held until ack
    flash_op_e op;
    logic [2:0] num;   // words minus one, erase ignores it
  } flash_ctrl_t;

endpackage

// ==== design/flash_ctrl_top.sv ====
/* two requesters on one bank; rd_data_o and err_addr_o are shared, so rd_data_o
   counts only with the owner's rvalid and err_addr_o only with an ack */
`timescale 1ns/1ps

module flash_ctrl_top import flash_ctrl_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  // software requester
  input  logic             sw_start_i,
  input  flash_op_e        sw_op_i,
  input  logic [2:0]       sw_num_i,
  input  logic [31:0]      sw_addr_i,
  input  logic             sw_wvalid_i,
  input  logic [WordW-1:0] sw_wdata_i,
  output logic             sw_wready_o,
  input  logic             sw_rready_i,
  output logic             sw_rvalid_o,
  output logic             sw_ack_o,
  output flash_err_e       sw_err_o,

  // hardware requester
  input  logic             hw_req_i,
  input  logic             hw_start_i,
  input  flash_op_e        hw_op_i,
  input  logic [2:0]       hw_num_i,
  input  logic [31:0]      hw_addr_i,
  input  logic             hw_wvalid_i,
  input  logic [WordW-1:0] hw_wdata_i,
  output logic             hw_wready_o,
  input  logic             hw_rready_i,
  output logic             hw_rvalid_o,
  output logic             hw_ack_o,
  output flash_err_e       hw_err_o,

  // shared outputs
  output logic [WordW-1:0] rd_data_o,
  output logic [31:0]      err_addr_o,
  output flash_sel_e       sel_o
);

  flash_ctrl_t         sw_ctrl, hw_ctrl;
  logic                rd_rvalid, rd_rready, rd_wvalid, rd_wready;
  logic [WordW-1:0]    rd_wdata;
  logic                prog_wvalid, prog_wready, prog_rvalid, prog_rready;
  logic [WordW-1:0]    prog_wdata, prog_rdata;
  logic                fifo_clr, bank_busy, bank_we;
  logic [WordIdxW-1:0] bank_addr;
  logic [WordW-1:0]    bank_wdata, bank_rdata;

  // pack requester controls
  assign sw_ctrl = '{start: sw_start_i, op: sw_op_i, num: sw_num_i};
  assign hw_ctrl = '{start: hw_start_i, op: hw_op_i, num: hw_num_i};

  flash_op_if op_if ();

  flash_ctrl_arb u_arb (
    .clk_i, .rst_ni,
    .sw_ctrl_i          (sw_ctrl),
    .hw_ctrl_i          (hw_ctrl),
    .sw_addr_i, .hw_addr_i, .hw_req_i,
    .sw_ack_o, .hw_ack_o, .sw_err_o, .hw_err_o,
    .sw_rready_i, .hw_rready_i, .sw_rvalid_o, .hw_rvalid_o,
    .sw_wvalid_i, .hw_wvalid_i, .sw_wdata_i, .hw_wdata_i,
    .sw_wready_o, .hw_wready_o,
    .rd_fifo_rvalid_i   (rd_rvalid),
    .rd_fifo_rready_o   (rd_rready),
    .prog_fifo_wready_i (prog_wready),
    .prog_fifo_wvalid_o (prog_wvalid),
    .prog_fifo_wdata_o  (prog_wdata),
    .fifo_clr_o         (fifo_clr),
    .flash_phy_busy_i   (bank_busy),
    .sel_o,
    .op                 (op_if.arb)
  );

  // engine to owner
  flash_fifo #(.Depth(RdFifoDepth)) u_rd_fifo (
    .clk_i, .rst_ni,
    .clr_i    (fifo_clr),
    .wvalid_i (rd_wvalid),
    .wready_o (rd_wready),
    .wdata_i  (rd_wdata),
    .rvalid_o (rd_rvalid),
    .rready_i (rd_rready),
    .rdata_o  (rd_data_o)
  );

  // owner to engine
  flash_fifo #(.Depth(ProgFifoDepth)) u_prog_fifo (
    .clk_i, .rst_ni,
    .clr_i    (fifo_clr),
    .wvalid_i (prog_wvalid),
    .wready_o (prog_wready),
    .wdata_i  (prog_wdata),
    .rvalid_o (prog_rvalid),
    .rready_i (prog_rready),
    .rdata_o  (prog_rdata)
  );

  flash_op_engine u_engine (
    .clk_i, .rst_ni,
    .rd_wvalid_o   (rd_wvalid),
    .rd_wready_i   (rd_wready),
    .rd_wdata_o    (rd_wdata),
    .prog_rvalid_i (prog_rvalid),
    .prog_rready_o (prog_rready),
    .prog_rdata_i  (prog_rdata),
    .bank_we_o     (bank_we),
    .bank_addr_o   (bank_addr),
    .bank_wdata_o  (bank_wdata),
    .bank_rdata_i  (bank_rdata),
    .op            (op_if.engine)
  );

  flash_bank u_bank (
    .clk_i, .rst_ni,
    .we_i    (bank_we),
    .addr_i  (bank_addr),
    .wdata_i (bank_wdata),
    .rdata_o (bank_rdata),
    .busy_o  (bank_busy)
  );

  assign err_addr_o = op_if.err_addr;

endmodule

// ==== design/flash_fifo.sv ====
/* word fifo, transfer when valid and ready meet; clr_i drops all entries
   in one cycle and wins over a write in the same cycle */
`timescale 1ns/1ps

module flash_fifo import flash_ctrl_pkg::*; #(
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [WordW-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [WordW-1:0] rdata_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [WordW-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [CntW-1:0]  count_q;
  logic             push, pop;

  assign wready_o = (count_q != CntW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push && !clr_i) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

// ==== design/flash_op_engine.sv ====
/* one word per cycle at best; program waits on an empty fifo with no timeout
   and an error leaves any later program words in the fifo */
`timescale 1ns/1ps

module flash_op_engine import flash_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  // read fifo write side
  output logic                rd_wvalid_o,
  input  logic                rd_wready_i,
  output logic [WordW-1:0]    rd_wdata_o,

  // program fifo read side
  input  logic                prog_rvalid_i,
  output logic                prog_rready_o,
  input  logic [WordW-1:0]    prog_rdata_i,

  // bank port
  output logic                bank_we_o,
  output logic [WordIdxW-1:0] bank_addr_o,
  output logic [WordW-1:0]    bank_wdata_o,
  input  logic [WordW-1:0]    bank_rdata_i,

  flash_op_if.engine          op
);

  typedef enum logic [1:0] {
    StIdle,
    StRun,
    StDone
  } state_e;

  state_e      state_q;
  flash_op_e   op_q;
  logic [2:0]  num_q, cnt_q;
  logic [31:0] base_q, err_addr_q, cur_addr;
  flash_err_e  err_q, err_now;
  logic        run, in_range, erased, step;

  // byte address of the word in flight
  assign cur_addr = base_q + {27'b0, cnt_q, 2'b00};
  assign in_range = (cur_addr < FlashBytes);
  assign erased   = (bank_rdata_i == '1);
  assign run      = (state_q == StRun);

  // word completes when its handshake lands
  always_comb begin
    unique case (op_q)
      FlashOpRead:    step = rd_wready_i;
      FlashOpProgram: step = prog_rvalid_i;
      default:        step = 1'b1;
    endcase
  end

  // range first, then the erased-word rule
  always_comb begin
    err_now = ErrNone;
    if (run && !in_range) begin
      err_now = ErrRange;
    end else if (run && op_q == FlashOpProgram && prog_rvalid_i && !erased) begin
      err_now = ErrProg;
    end
  end

  assign rd_wvalid_o   = run && in_range && (op_q == FlashOpRead);
  assign rd_wdata_o    = bank_rdata_i;
  assign prog_rready_o = run && in_range && (op_q == FlashOpProgram);
  assign bank_we_o     = run && in_range &&
                         ((op_q == FlashOpProgram && prog_rvalid_i && erased) ||
                          (op_q == FlashOpErase));
  assign bank_addr_o   = cur_addr[WordIdxW+1:2];
  assign bank_wdata_o  = (op_q == FlashOpErase) ? '1 : prog_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      cnt_q   <= '0;
      err_q   <= ErrNone;
    end else begin
      unique case (state_q)
        StIdle: begin
          if (op.ctrl.start) begin
            cnt_q   <= '0;
            err_q   <= ErrNone;
            state_q <= StRun;
          end
        end
        StRun: begin
          if (err_now != ErrNone) begin
            // first failure ends the operation
            err_q   <= err_now;
            state_q <= StDone;
          end else if (step) begin
            if (cnt_q == num_q) begin
              state_q <= StDone;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // latched request, erase snaps down to its page
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && op.ctrl.start) begin
      op_q       <= op.ctrl.op;
      num_q      <= (op.ctrl.op == FlashOpErase) ? 3'(PageWords - 1) : op.ctrl.num;
      base_q     <= (op.ctrl.op == FlashOpErase) ? (op.addr & ~32'(PageBytes - 1)) : op.addr;
      err_addr_q <= '0;
    end else if (err_now != ErrNone) begin
      err_addr_q <= cur_addr;
    end
  end

  assign op.ack      = (state_q == StDone);
  assign op.err      = err_q;
  assign op.err_addr = err_addr_q;

endmodule

// ==== design/flash_op_if.sv ====
/* arbiter to engine link; ctrl is all zero while no requester owns the bank */
`timescale 1ns/1ps

interface flash_op_if import flash_ctrl_pkg::*; ();

  // request side, driven by the arbiter
  flash_ctrl_t ctrl;
  logic [31:0] addr;

  // feedback, one cycle pulse from the engine
  logic        ack;
  flash_err_e  err;
  logic [31:0] err_addr;

  modport arb (
    output ctrl,
    output addr,
    input  ack,
    input  err,
    input  err_addr
  );

  modport engine (
    input  ctrl,
    input  addr,
    output ack,
    output err,
    output err_addr
  );

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the flash controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_flash_ctrl \
  -f vlog.f -o tb_flash_ctrl

# the simulator exit code is not used, the log decides
./obj_dir/tb_flash_ctrl 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== test/tb_flash_ctrl.sv ====
/* testbench for flash_ctrl_top; byte addresses stay word aligned and the
   model only knows the flash rules, not the engine timing */
`timescale 1ns/1ps

module tb_flash_ctrl import flash_ctrl_pkg::*; ();

  localparam int ClkPeriod  = 40;
  localparam int NumRandOps = 60;
  // generous bound per operation including takeover waits
  localparam int OpCycles   = 40;
  localparam int WatchdogCycles = 4 * NumWords + (24 + NumRandOps) * OpCycles;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             sw_start_i, hw_start_i, hw_req_i;
  flash_op_e        sw_op_i, hw_op_i;
  logic [2:0]       sw_num_i, hw_num_i;
  logic [31:0]      sw_addr_i, hw_addr_i;
  logic             sw_wvalid_i, hw_wvalid_i, sw_rready_i, hw_rready_i;
  logic [WordW-1:0] sw_wdata_i, hw_wdata_i;
  logic             sw_wready_o, hw_wready_o, sw_rvalid_o, hw_rvalid_o;
  logic             sw_ack_o, hw_ack_o;
  flash_err_e       sw_err_o, hw_err_o;
  logic [WordW-1:0] rd_data_o;
  logic [31:0]      err_addr_o;
  flash_sel_e       sel_o;

  // reference flash array and expectations
  logic [WordW-1:0] ref_mem [NumWords];
  logic [WordW-1:0] pdata [PageWords];
  logic [WordW-1:0] tx_q [$];
  logic [WordW-1:0] sw_rd_q [$];
  logic [WordW-1:0] hw_rd_q [$];
  logic [33:0]      sw_ack_q [$];
  logic [33:0]      hw_ack_q [$];
  logic [33:0]      exp_resp;
  int               sw_ack_count = 0;
  int               sw_acks_before;
  integer           seed = 32'hd59e_064f;
  logic [31:0]      r;
  logic             pick_hw;

  flash_ctrl_top dut_i (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort(input string why);
    $display("%s at %0t ns", why, $time);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // range is checked before the erased-word rule and erase clears a whole page
  function automatic logic [33:0] model_op(input logic hw, input flash_op_e op,
                                           input logic [31:0] addr, input logic [2:0] num);
    logic [31:0]         base;
    logic [31:0]         a;
    logic [WordIdxW-1:0] idx;
    int                  words;
    base  = (op == FlashOpErase) ? addr - (addr % PageBytes) : addr;
    words = (op == FlashOpErase) ? PageWords : int'(num) + 1;
    for (int i = 0; i < words; i++) begin
      a   = base + 32'(4 * i);
      idx = a[WordIdxW+1:2];
      if (a >= FlashBytes) begin
        return {ErrRange, a};
      end
      if (op == FlashOpRead) begin
        if (hw) begin
          hw_rd_q.push_back(ref_mem[idx]);
        end else begin
          sw_rd_q.push_back(ref_mem[idx]);
        end
      end else if (op == FlashOpProgram) begin
        // the failing word is still taken from the fifo
        tx_q.push_back(pdata[i]);
        if (ref_mem[idx] !== '1) begin
          return {ErrProg, a};
        end
        ref_mem[idx] = pdata[i];
      end else begin
        ref_mem[idx] = '1;
      end
    end
    return {ErrNone, 32'h0};
  endfunction

  // push write data toward the program fifo and drop start once acked
  task automatic feed(input logic hw, input logic stop);
    logic busy;
    busy = (tx_q.size() != 0) && !stop;
    if (hw) begin
      hw_wvalid_i = busy;
      if (stop) begin
        hw_start_i = 1'b0;
      end
      if (busy) begin
        hw_wdata_i = tx_q[0];
        if (hw_wready_o) begin
          void'(tx_q.pop_front());
        end
      end
    end else begin
      sw_wvalid_i = busy;
      if (stop) begin
        sw_start_i = 1'b0;
      end
      if (busy) begin
        sw_wdata_i = tx_q[0];
        if (sw_wready_o) begin
          void'(tx_q.pop_front());
        end
      end
    end
  endtask

  // called on a falling edge
  task automatic issue(input logic hw, input flash_op_e op, input logic [31:0] addr,
                       input logic [2:0] num, input logic drain);
    logic [33:0] resp;
    resp = model_op(hw, op, addr, num);
    if (hw) begin
      hw_ack_q.push_back(resp);
      hw_start_i = 1'b1;
      hw_op_i    = op;
      hw_num_i   = num;
      hw_addr_i  = addr;
    end else begin
      sw_ack_q.push_back(resp);
      // words that will be left unread
      if (!drain) begin
        sw_rd_q.delete();
      end
      sw_start_i = 1'b1;
      sw_op_i    = op;
      sw_num_i   = num;
      sw_addr_i  = addr;
    end
    feed(hw, 1'b0);
  endtask

  task automatic complete(input logic hw);
    logic acked;
    int   pending;
    acked = 1'b0;
    while (!acked) begin
      @(negedge clk_i);
      acked = hw ? hw_ack_o : sw_ack_o;
      feed(hw, acked);
    end
    // read words can trail the ack
    pending = hw ? hw_rd_q.size() : sw_rd_q.size();
    while (pending != 0) begin
      @(negedge clk_i);
      pending = hw ? hw_rd_q.size() : sw_rd_q.size();
    end
    check_eq(tx_q.size(), 0, "program words left unsent");
  endtask

  task automatic run_op(input logic hw, input flash_op_e op, input logic [31:0] addr,
                        input logic [2:0] num);
    issue(hw, op, addr, num, 1'b1);
    complete(hw);
  endtask

  task automatic wait_sel(input flash_sel_e want);
    int n;
    n = 0;
    while (sel_o != want) begin
      @(negedge clk_i);
      n++;
      if (n > NumWords + 8) begin
        abort($sformatf("owner never became %s", want.name()));
      end
    end
  endtask

  task automatic fill_pdata();
    for (int i = 0; i < PageWords; i++) begin
      pdata[i] = $random(seed);
    end
  endtask

  // compare acks and read beats on the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (sw_ack_o) begin
        sw_ack_count++;
        check_eq(sw_ack_q.size() != 0, 1, "sw ack with none outstanding");
        exp_resp = sw_ack_q.pop_front();
        check_eq({sw_err_o, err_addr_o}, exp_resp, "sw err and err_addr");
      end
      if (hw_ack_o) begin
        check_eq(hw_ack_q.size() != 0, 1, "hw ack with none outstanding");
        exp_resp = hw_ack_q.pop_front();
        check_eq({hw_err_o, err_addr_o}, exp_resp, "hw err and err_addr");
      end
      if (sw_rvalid_o && sw_rready_i) begin
        check_eq(sw_rd_q.size() != 0, 1, "unexpected sw read beat");
        check_eq(rd_data_o, sw_rd_q.pop_front(), "sw read data");
      end
      if (hw_rvalid_o && hw_rready_i) begin
        check_eq(hw_rd_q.size() != 0, 1, "unexpected hw read beat");
        check_eq(rd_data_o, hw_rd_q.pop_front(), "hw read data");
      end
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    abort("watchdog expired before the tests finished");
  end

  initial begin
    {sw_start_i, hw_start_i, hw_req_i, sw_wvalid_i, hw_wvalid_i} = '0;
    {sw_num_i, hw_num_i, sw_addr_i, hw_addr_i, sw_wdata_i, hw_wdata_i} = '0;
    sw_op_i     = FlashOpRead;
    hw_op_i     = FlashOpRead;
    sw_rready_i = 1'b1;
    hw_rready_i = 1'b1;
    for (int i = 0; i < NumWords; i++) begin
      ref_mem[i] = '1;
    end
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // quiet while the bank fills itself
    @(negedge clk_i);
    check_eq(sel_o, NoneSel, "owner after reset");
    check_eq({sw_ack_o, hw_ack_o, sw_rvalid_o, hw_rvalid_o}, 0, "acks and valids after reset");
    check_eq({sw_wready_o, hw_wready_o}, 0, "wready after reset");
    wait_sel(HwSel);
    wait_sel(SwSel);
    for (int p = 0; p < NumWords / PageWords; p++) begin
      run_op(1'b0, FlashOpRead, 32'(p * PageBytes), 3'd7);
    end

    // erase, program, read back
    fill_pdata();
    run_op(1'b0, FlashOpErase, 32'h24, 3'd0);
    run_op(1'b0, FlashOpProgram, 32'h24, 3'd4);
    run_op(1'b0, FlashOpRead, 32'h20, 3'd5);

    // program over data and expect the old word to stay
    fill_pdata();
    run_op(1'b0, FlashOpProgram, 32'h24, 3'd0);
    run_op(1'b0, FlashOpRead, 32'h24, 3'd0);

    // read past the end of the bank
    run_op(1'b0, FlashOpRead, FlashBytes - 8, 3'd3);

    // takeover with sw words still in the read fifo
    sw_rready_i = 1'b0;
    issue(1'b0, FlashOpRead, 32'h40, 3'd2, 1'b0);
    complete(1'b0);
    check_eq(sw_rvalid_o, 1, "sw words waiting before takeover");
    hw_req_i = 1'b1;
    wait_sel(HwSel);
    check_eq(hw_rvalid_o, 0, "hw rvalid right after takeover");
    sw_rready_i    = 1'b1;
    sw_acks_before = sw_ack_count;
    issue(1'b0, FlashOpRead, 32'h80, 3'd3, 1'b1);
    fill_pdata();
    run_op(1'b1, FlashOpErase, 32'h48, 3'd0);
    run_op(1'b1, FlashOpProgram, 32'h40, 3'd3);
    check_eq(hw_rvalid_o, 0, "hw rvalid before any hw read");
    run_op(1'b1, FlashOpRead, 32'h40, 3'd7);
    check_eq(sw_ack_count, sw_acks_before, "sw ack while hw owns the bank");
    hw_req_i = 1'b0;
    complete(1'b0);

    // random mix from both sides with a few addresses past the end
    for (int k = 0; k < NumRandOps; k++) begin
      r       = $random(seed);
      pick_hw = r[31];
      fill_pdata();
      if (pick_hw) begin
        hw_req_i = 1'b1;
        wait_sel(HwSel);
      end
      run_op(pick_hw, flash_op_e'(2'(r[7:0] % 3)), 32'((r[23:8] % 72) * 4), r[26:24]);
      if (pick_hw) begin
        hw_req_i = 1'b0;
        wait_sel(SwSel);
      end
    end

    repeat (2) @(negedge clk_i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/flash_ctrl_pkg.sv
design/flash_op_if.sv
design/flash_ctrl_arb.sv
design/flash_fifo.sv
design/flash_op_engine.sv
design/flash_bank.sv
design/flash_ctrl_top.sv
test/tb_flash_ctrl.sv
